//--- design/exePkg.sv
// execute stage shared definitions: widths, exception bit map, ALU and immediate encodings
package exePkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;
    localparam int ExcWidth     = 9;

    // positions in the exception vector carried down the pipe
    localparam int ExcInterrupt = 0;
    localparam int ExcFetchAddr = 1;  // misaligned instruction fetch
    localparam int ExcReserved  = 2;  // reserved instruction
    localparam int ExcSyscall   = 3;
    localparam int ExcBreak     = 4;
    localparam int ExcEret      = 5;
    localparam int ExcStoreAddr = 6;  // bad store address
    localparam int ExcLoadAddr  = 7;  // bad load address
    localparam int ExcOverflow  = 8;  // set in execute only

    // ALU operations as issued by decode
    typedef enum logic [4:0] {
        OpAdd  = 5'd0,   // trapping
        OpAddu = 5'd1,
        OpSub  = 5'd2,   // trapping
        OpSubu = 5'd3,
        OpOr   = 5'd4,
        OpNor  = 5'd5,
        OpXor  = 5'd6,
        OpAnd  = 5'd7,
        OpSll  = 5'd8,   // shift by shamt
        OpSllv = 5'd9,   // shift by rs
        OpSrl  = 5'd10,
        OpSrlv = 5'd11,
        OpSra  = 5'd12,
        OpSrav = 5'd13,
        OpSlt  = 5'd14,
        OpSltu = 5'd15,
        OpClz  = 5'd16,
        OpClo  = 5'd17,
        OpNop  = 5'd18   // result forced to zero
    } aluOpT;

    // source of operand B
    typedef enum logic [1:0] {
        ImmNone = 2'd0,  // rtData
        ImmSign = 2'd1,  // sign-extended imm
        ImmZero = 2'd2   // zero-extended imm
    } immModeT;

endpackage

//--- design/countBits.sv
// leading zero / leading one counter, scans a word from the MSB down
`timescale 1ns/10ps

module countBits (
    input  logic                         countOnes,  // 1 counts ones, 0 counts zeros
    input  logic [exePkg::DataWidth-1:0] value,
    output logic [exePkg::DataWidth-1:0] count
);

    logic stop;  // first mismatching bit seen

    always_comb begin
        count = '0;
        stop  = 1'b0;
        for (int i = exePkg::DataWidth - 1; i >= 0; i--) begin
            if (!stop && (value[i] == countOnes)) begin
                count = count + 1'b1;
            end else begin
                stop = 1'b1;  // run of leading bits ends here
            end
        end
    end

    // all-match word gives the full width, 32

endmodule

//--- design/operandSelect.sv
// operand mux for the ALU: picks rs or shamt for A, register or extended immediate for B
`timescale 1ns/10ps

module operandSelect (
    input  exePkg::aluOpT                aluOp,
    input  exePkg::immModeT              immMode,
    input  logic [exePkg::DataWidth-1:0] rsData,
    input  logic [exePkg::DataWidth-1:0] rtData,
    input  logic [15:0]                  imm,
    input  logic [4:0]                   shamt,
    output logic [exePkg::DataWidth-1:0] opA,
    output logic [exePkg::DataWidth-1:0] opB
);

    logic constShift;  // shift amount comes from the instruction word

    assign constShift = (aluOp == exePkg::OpSll) ||
                        (aluOp == exePkg::OpSrl) ||
                        (aluOp == exePkg::OpSra);

    // operand A
    always_comb begin
        if (constShift) begin
            opA = {{(exePkg::DataWidth - 5){1'b0}}, shamt};
        end else begin
            opA = rsData;
        end
    end

    // operand B, extended as decode asks
    always_comb begin
        unique case (immMode)
            exePkg::ImmSign: opB = {{(exePkg::DataWidth - 16){imm[15]}}, imm};
            exePkg::ImmZero: opB = {{(exePkg::DataWidth - 16){1'b0}}, imm};
            default:         opB = rtData;  // ImmNone and the unused code
        endcase
    end

endmodule

//--- design/alu.sv
// execute ALU: add/sub, logic, shifts, compares, leading bit counts, signed overflow detect
`timescale 1ns/10ps

module alu (
    input  exePkg::aluOpT                aluOp,
    input  logic [exePkg::DataWidth-1:0] opA,
    input  logic [exePkg::DataWidth-1:0] opB,
    input  logic [exePkg::ExcWidth-1:0]  excIn,
    output logic [exePkg::DataWidth-1:0] aluResult,
    output logic [exePkg::ExcWidth-1:0]  excOut
);

    localparam int Msb = exePkg::DataWidth - 1;

    logic [Msb:0] sum;
    logic [Msb:0] diff;
    logic [Msb:0] countOut;
    logic         countOnes;
    logic         sltSigned;
    logic         sltUnsigned;
    logic         addOvf;
    logic         subOvf;
    logic [4:0]   shiftAmt;

    assign sum      = opA + opB;
    assign diff     = opA - opB;
    assign shiftAmt = opA[4:0];  // constant or variable, already chosen upstream

    assign sltSigned   = $signed(opA) < $signed(opB);
    assign sltUnsigned = opA < opB;

    assign countOnes = (aluOp == exePkg::OpClo);

    countBits uCountBits (
        .countOnes (countOnes),
        .value     (opA),
        .count     (countOut)
    );

    // same-sign operands whose result flips sign
    assign addOvf = (opA[Msb] == opB[Msb]) && (sum[Msb] != opA[Msb]);
    assign subOvf = (opA[Msb] != opB[Msb]) && (diff[Msb] != opA[Msb]);  // B sign inverted

    always_comb begin
        unique case (aluOp)
            exePkg::OpAdd,
            exePkg::OpAddu: aluResult = sum;
            exePkg::OpSub,
            exePkg::OpSubu: aluResult = diff;
            exePkg::OpOr:   aluResult = opA | opB;
            exePkg::OpNor:  aluResult = ~(opA | opB);
            exePkg::OpXor:  aluResult = opA ^ opB;
            exePkg::OpAnd:  aluResult = opA & opB;
            exePkg::OpSll,
            exePkg::OpSllv: aluResult = opB << shiftAmt;
            exePkg::OpSrl,
            exePkg::OpSrlv: aluResult = opB >> shiftAmt;
            exePkg::OpSra,
            exePkg::OpSrav: aluResult = $signed(opB) >>> shiftAmt;  // sign fill
            exePkg::OpSlt:  aluResult = {{Msb{1'b0}}, sltSigned};
            exePkg::OpSltu: aluResult = {{Msb{1'b0}}, sltUnsigned};
            exePkg::OpClz,
            exePkg::OpClo:  aluResult = countOut;
            default:        aluResult = '0;  // OpNop and unused codes
        endcase
    end

    // pass the carried exceptions through, overflow is owned here
    always_comb begin
        excOut = excIn;
        excOut[exePkg::ExcOverflow] = ((aluOp == exePkg::OpAdd) && addOvf) ||
                                      ((aluOp == exePkg::OpSub) && subOvf);
    end

endmodule

//--- design/exeMemReg.sv
// EXE/MEM pipeline register with stall hold, flush clear and write kill on overflow
`timescale 1ns/10ps

module exeMemReg (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            stall,     // hold everything
    input  logic                            flush,     // kill the captured slot
    input  logic                            inValid,
    input  logic                            regWrite,
    input  logic [exePkg::DataWidth-1:0]    aluResult,
    input  logic [exePkg::RegAddrWidth-1:0] destReg,
    input  logic [exePkg::ExcWidth-1:0]     excIn,
    output logic                            memValid,
    output logic                            memRegWrite,
    output logic [exePkg::DataWidth-1:0]    memResult,
    output logic [exePkg::RegAddrWidth-1:0] memDest,
    output logic [exePkg::ExcWidth-1:0]     memExc
);

    logic writeEn;

    // trapping instruction must not commit its result
    assign writeEn = inValid && regWrite && !excIn[exePkg::ExcOverflow];

    // control and exception bits, flush wins over stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memValid    <= 1'b0;
            memRegWrite <= 1'b0;
            memExc      <= '0;
        end else if (flush) begin
            memValid    <= 1'b0;
            memRegWrite <= 1'b0;
            memExc      <= '0;  // no stale trap from a killed slot
        end else if (!stall) begin
            memValid    <= inValid;
            memRegWrite <= writeEn;
            memExc      <= excIn;
        end
    end

    // result and destination
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memResult <= '0;
            memDest   <= '0;
        end else if (!stall) begin
            memResult <= aluResult;
            memDest   <= destReg;
        end
    end

endmodule

//--- design/exeStage.sv
// execute stage top: operand select, ALU and the EXE/MEM register
`timescale 1ns/10ps

module exeStage (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            stall,
    input  logic                            flush,
    input  logic                            inValid,
    input  exePkg::aluOpT                   aluOp,
    input  exePkg::immModeT                 immMode,
    input  logic [exePkg::DataWidth-1:0]    rsData,
    input  logic [exePkg::DataWidth-1:0]    rtData,
    input  logic [15:0]                     imm,
    input  logic [4:0]                      shamt,
    input  logic [exePkg::RegAddrWidth-1:0] destReg,
    input  logic                            regWrite,
    input  logic [exePkg::ExcWidth-1:0]     excIn,
    output logic                            memValid,
    output logic [exePkg::DataWidth-1:0]    memResult,
    output logic [exePkg::RegAddrWidth-1:0] memDest,
    output logic                            memRegWrite,
    output logic [exePkg::ExcWidth-1:0]     memExc
);

    logic [exePkg::DataWidth-1:0] opA;
    logic [exePkg::DataWidth-1:0] opB;
    logic [exePkg::DataWidth-1:0] aluResult;
    logic [exePkg::ExcWidth-1:0]  aluExc;  // excIn plus overflow

    operandSelect uOperandSelect (
        .aluOp   (aluOp),
        .immMode (immMode),
        .rsData  (rsData),
        .rtData  (rtData),
        .imm     (imm),
        .shamt   (shamt),
        .opA     (opA),
        .opB     (opB)
    );

    alu uAlu (
        .aluOp     (aluOp),
        .opA       (opA),
        .opB       (opB),
        .excIn     (excIn),
        .aluResult (aluResult),
        .excOut    (aluExc)
    );

    exeMemReg uExeMemReg (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .flush       (flush),
        .inValid     (inValid),
        .regWrite    (regWrite),
        .aluResult   (aluResult),
        .destReg     (destReg),
        .excIn       (aluExc),
        .memValid    (memValid),
        .memRegWrite (memRegWrite),
        .memResult   (memResult),
        .memDest     (memDest),
        .memExc      (memExc)
    );

endmodule

//--- dv/exeTb.sv
// execute stage testbench driving random and directed instructions against a one-cycle model
`timescale 1ns/10ps

module exeTb;

    logic                            clk;
    logic                            arstN;
    logic                            stall;
    logic                            flush;
    logic                            inValid;
    exePkg::aluOpT                   aluOp;
    exePkg::immModeT                 immMode;
    logic [exePkg::DataWidth-1:0]    rsData;
    logic [exePkg::DataWidth-1:0]    rtData;
    logic [15:0]                     imm;
    logic [4:0]                      shamt;
    logic [exePkg::RegAddrWidth-1:0] destReg;
    logic                            regWrite;
    logic [exePkg::ExcWidth-1:0]     excIn;
    logic                            memValid;
    logic [exePkg::DataWidth-1:0]    memResult;
    logic [exePkg::RegAddrWidth-1:0] memDest;
    logic                            memRegWrite;
    logic [exePkg::ExcWidth-1:0]     memExc;

    // reference model state one cycle behind the inputs like the DUT
    logic                            expValid;
    logic                            expRegWrite;
    logic [exePkg::DataWidth-1:0]    expResult;
    logic [exePkg::RegAddrWidth-1:0] expDest;
    logic [exePkg::ExcWidth-1:0]     expExc;
    logic [exePkg::DataWidth-1:0]    refResult;
    logic                            refOvf;

    int errorCount;
    int cycleCount;
    int cycleLimit = 1000;  // ~650 cycles of stimulus plus margin

    // overflow corner operands with A and B paired by index
    logic [31:0] ovfA [6] = '{32'h7fffffff, 32'h80000000, 32'h00000001,
                              32'h7fffffff, 32'h80000000, 32'hfffffffe};
    logic [31:0] ovfB [6] = '{32'h00000001, 32'hffffffff, 32'h00000001,
                              32'hffffffff, 32'h00000001, 32'h7fffffff};
    logic [31:0] countVals [6] = '{32'h00000000, 32'hffffffff, 32'h80000000,
                                   32'h7fffffff, 32'hfff00000, 32'h0000ffff};

    exeStage dut (
        .clk         (clk),
        .arstN       (arstN),
        .stall       (stall),
        .flush       (flush),
        .inValid     (inValid),
        .aluOp       (aluOp),
        .immMode     (immMode),
        .rsData      (rsData),
        .rtData      (rtData),
        .imm         (imm),
        .shamt       (shamt),
        .destReg     (destReg),
        .regWrite    (regWrite),
        .excIn       (excIn),
        .memValid    (memValid),
        .memResult   (memResult),
        .memDest     (memDest),
        .memRegWrite (memRegWrite),
        .memExc      (memExc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] operandB(input exePkg::immModeT mode,
                                             input logic [31:0] rt, input logic [15:0] im);
        if (mode == exePkg::ImmSign) begin
            return {{16{im[15]}}, im};
        end else if (mode == exePkg::ImmZero) begin
            return {16'h0000, im};
        end
        return rt;
    endfunction

    // number of leading bits equal to bitVal
    function automatic int leadingCount(input logic [31:0] value, input logic bitVal);
        int n;
        n = 0;
        while (n < 32 && value[31 - n] == bitVal) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic [31:0] expectedResult(input exePkg::aluOpT op,
                                                   input logic [31:0] rs, input logic [31:0] b,
                                                   input logic [4:0] sa);
        logic [4:0] amt;
        amt = (op == exePkg::OpSll || op == exePkg::OpSrl || op == exePkg::OpSra) ? sa : rs[4:0];
        case (op)
            exePkg::OpAdd, exePkg::OpAddu: return rs + b;
            exePkg::OpSub, exePkg::OpSubu: return rs - b;
            exePkg::OpOr:                  return rs | b;
            exePkg::OpNor:                 return ~(rs | b);
            exePkg::OpXor:                 return rs ^ b;
            exePkg::OpAnd:                 return rs & b;
            exePkg::OpSll, exePkg::OpSllv: return b << amt;
            exePkg::OpSrl, exePkg::OpSrlv: return b >> amt;
            exePkg::OpSra, exePkg::OpSrav: return 32'($signed(b) >>> amt);
            exePkg::OpSlt:                 return ($signed(rs) < $signed(b)) ? 32'd1 : 32'd0;
            exePkg::OpSltu:                return (rs < b) ? 32'd1 : 32'd0;
            exePkg::OpClz:                 return 32'(leadingCount(rs, 1'b0));
            exePkg::OpClo:                 return 32'(leadingCount(rs, 1'b1));
            default:                       return 32'd0;
        endcase
    endfunction

    // true signed result out of 32-bit range, trapping ops only
    function automatic logic signedOverflow(input exePkg::aluOpT op,
                                            input logic [31:0] rs, input logic [31:0] b);
        longint full;
        if (op == exePkg::OpAdd) begin
            full = longint'($signed(rs)) + longint'($signed(b));
        end else if (op == exePkg::OpSub) begin
            full = longint'($signed(rs)) - longint'($signed(b));
        end else begin
            return 1'b0;
        end
        return (full > 64'sd2147483647) || (full < -64'sd2147483648);
    endfunction

    always_comb begin
        refResult = expectedResult(aluOp, rsData, operandB(immMode, rtData, imm), shamt);
        refOvf    = signedOverflow(aluOp, rsData, operandB(immMode, rtData, imm));
    end

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expValid    <= 1'b0;
            expRegWrite <= 1'b0;
            expExc      <= '0;
            expResult   <= '0;
            expDest     <= '0;
        end else begin
            if (flush) begin
                expValid    <= 1'b0;
                expRegWrite <= 1'b0;
                expExc      <= '0;
            end else if (!stall) begin
                expValid    <= inValid;
                expRegWrite <= inValid && regWrite && !refOvf;  // trap kills the write
                expExc      <= excIn;
                expExc[exePkg::ExcOverflow] <= refOvf;
            end
            if (!stall) begin
                expResult <= refResult;
                expDest   <= destReg;
            end
        end
    end

    // outputs are stable at the falling edge
    validCheck: assert property (@(negedge clk) memValid === expValid)
        else begin
            errorCount++;
            $display("ERROR %0t: memValid is %b, expected %b", $time, memValid, expValid);
        end
    writeCheck: assert property (@(negedge clk) memRegWrite === expRegWrite)
        else begin
            errorCount++;
            $display("ERROR %0t: memRegWrite is %b, expected %b",
                     $time, memRegWrite, expRegWrite);
        end
    resultCheck: assert property (@(negedge clk) memResult === expResult)
        else begin
            errorCount++;
            $display("ERROR %0t: memResult is %h, expected %h", $time, memResult, expResult);
        end
    destCheck: assert property (@(negedge clk) memDest === expDest)
        else begin
            errorCount++;
            $display("ERROR %0t: memDest is %0d, expected %0d", $time, memDest, expDest);
        end
    excCheck: assert property (@(negedge clk) memExc === expExc)
        else begin
            errorCount++;
            $display("ERROR %0t: memExc is %b, expected %b", $time, memExc, expExc);
        end

    task automatic sendInstr(input exePkg::aluOpT op, input exePkg::immModeT mode,
                             input logic [31:0] rs, input logic [31:0] rt, input logic [15:0] im);
        @(negedge clk);
        inValid  = 1'b1;
        aluOp    = op;
        immMode  = mode;
        rsData   = rs;
        rtData   = rt;
        imm      = im;
        shamt    = 5'($urandom);
        destReg  = 5'($urandom);
        regWrite = 1'b1;
        excIn    = exePkg::ExcWidth'($urandom);  // overflow bit here must be replaced
        stall    = 1'b0;
        flush    = 1'b0;
    endtask

    // call right after sendInstr so the instruction stays on the inputs
    task automatic holdStall(input int cycles);
        stall = 1'b1;
        repeat (cycles) @(negedge clk);
        stall = 1'b0;
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", cycleLimit);
        $display("errors: %0d", errorCount);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] rs;
        errorCount = 0;
        void'($urandom(32'hd22d));
        arstN    = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        inValid  = 1'b0;
        aluOp    = exePkg::OpNop;
        immMode  = exePkg::ImmNone;
        rsData   = '0;
        rtData   = '0;
        imm      = '0;
        shamt    = '0;
        destReg  = '0;
        regWrite = 1'b0;
        excIn    = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        assert (memValid === 1'b0 && memRegWrite === 1'b0)
            else begin
                errorCount++;
                $display("ERROR %0t: memValid or memRegWrite set after reset", $time);
            end

        // every op with every operand B source
        for (int op = 0; op <= 18; op++) begin
            for (int mode = 0; mode <= 2; mode++) begin
                sendInstr(exePkg::aluOpT'(op), exePkg::immModeT'(mode),
                          $urandom, $urandom, 16'($urandom));
            end
        end

        foreach (countVals[i]) begin
            sendInstr(exePkg::OpClz, exePkg::ImmNone, countVals[i], $urandom, '0);
            sendInstr(exePkg::OpClo, exePkg::ImmNone, countVals[i], $urandom, '0);
        end

        // trapping and non-trapping add/sub on the sign boundaries
        foreach (ovfA[i]) begin
            sendInstr(exePkg::OpAdd, exePkg::ImmNone, ovfA[i], ovfB[i], '0);
            sendInstr(exePkg::OpSub, exePkg::ImmNone, ovfA[i], ovfB[i], '0);
            sendInstr(exePkg::OpAddu, exePkg::ImmNone, ovfA[i], ovfB[i], '0);
            sendInstr(exePkg::OpSubu, exePkg::ImmNone, ovfA[i], ovfB[i], '0);
        end

        sendInstr(exePkg::OpXor, exePkg::ImmNone, $urandom, $urandom, '0);
        sendInstr(exePkg::OpOr, exePkg::ImmZero, $urandom, $urandom, 16'($urandom));
        holdStall(3);
        sendInstr(exePkg::OpAnd, exePkg::ImmNone, $urandom, $urandom, '0);
        flush = 1'b1;  // plain flush pulse
        sendInstr(exePkg::OpAdd, exePkg::ImmSign, $urandom, $urandom, 16'($urandom));
        @(negedge clk);  // add now sits valid in the register
        stall = 1'b1;
        flush = 1'b1;  // flush wins over stall
        @(negedge clk);
        flush = 1'b0;
        holdStall(2);

        for (int n = 0; n < 400; n++) begin
            rs = $urandom;
            if ($urandom_range(0, 3) == 0) begin
                rs = rs >> $urandom_range(0, 31);  // longer leading runs for clz/clo
            end
            sendInstr(exePkg::aluOpT'($urandom_range(0, 18)),
                      exePkg::immModeT'($urandom_range(0, 2)), rs, $urandom, 16'($urandom));
            inValid  = ($urandom_range(0, 7) != 0);
            regWrite = $urandom_range(0, 1);
            case ($urandom_range(0, 15))
                0, 1:    holdStall($urandom_range(1, 3));
                2:       flush = 1'b1;
                default: ;
            endcase
        end

        @(negedge clk);
        inValid = 1'b0;
        repeat (2) @(negedge clk);
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sources.f
design/exePkg.sv
design/countBits.sv
design/operandSelect.sv
design/alu.sv
design/exeMemReg.sv
design/exeStage.sv
dv/exeTb.sv
